// File: design/AguPkg.sv
`default_nettype none

package AguPkg;

    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } MemOpcode;

    typedef logic [5:0] SeqNum;

    typedef enum logic [1:0] {
        NONE         = 2'd0,
        MISALIGN     = 2'd1,
        PAGE_FAULT   = 2'd2,
        ACCESS_FAULT = 2'd3
    } AguException;

    typedef enum logic {
        PRIV_USER       = 1'b0,
        PRIV_SUPERVISOR = 1'b1
    } PrivMode;

    typedef struct packed {
        logic        valid;
        MemOpcode    opcode;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [5:0]  tagDst;
        SeqNum       sqN;
    } IssueUop;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [5:0]  tagDst;
        SeqNum       sqN;
        logic [1:0]  size;
        logic        signExtend;
        logic        isLoad;
        logic        isStore;
        logic [3:0]  wmask;
        AguException exception;
    } AguUop;

    // Taken flush discards every op younger than sqN
    typedef struct packed {
        logic  taken;
        SeqNum sqN;
    } BranchFlush;

    typedef struct packed {
        logic    sv32en;
        PrivMode priv;
        logic    sum;
    } VmemState;

    typedef struct packed {
        logic        valid;
        logic [19:0] vpn;
    } TlbLookup;

    typedef struct packed {
        logic        hit;
        logic [19:0] ppn;
        logic [2:0]  rwx;
        logic        user;
        logic        pageFault;
    } TlbEntry;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } PageWalkReq;

    typedef struct packed {
        logic        busy;
        logic [1:0]  rqId;
        logic        valid;
        logic [19:0] vpn;
        logic [19:0] ppn;
        logic [2:0]  rwx;
        logic        user;
        logic        pageFault;
    } PageWalkRes;

    typedef struct packed {
        logic        valid;
        SeqNum       sqN;
        logic [31:0] tval;
    } TvalReport;

    // Wrap-around age test, true when sqN is younger than branchSqN
    function automatic logic isYounger(SeqNum sqN, SeqNum branchSqN);
        return $signed(sqN - branchSqN) > 0;
    endfunction

    function automatic logic isLegalAddr(logic [31:0] addr);
        return (addr < 32'h1000_0000) || (addr[31:12] == 20'h20000);
    endfunction

endpackage

`default_nettype wire

// File: design/MemOpDecode.sv
`timescale 1ns/1ps
`default_nettype none

module MemOpDecode (
    input  wire AguPkg::IssueUop uopIn,
    input  wire [31:0]           addr,
    output AguPkg::AguUop        decoded
);

    always_comb begin
        decoded = '0;
        decoded.valid = uopIn.valid;
        decoded.addr = addr;
        decoded.tagDst = uopIn.tagDst;
        decoded.sqN = uopIn.sqN;
        decoded.exception = AguPkg::NONE;

        case (uopIn.opcode)
            AguPkg::LB: begin
                decoded.size = 2'd0;
                decoded.signExtend = 1'b1;
                decoded.isLoad = 1'b1;
            end
            AguPkg::LH: begin
                decoded.size = 2'd1;
                decoded.signExtend = 1'b1;
                decoded.isLoad = 1'b1;
            end
            AguPkg::LW: begin
                decoded.size = 2'd2;
                decoded.isLoad = 1'b1;
            end
            AguPkg::LBU: begin
                decoded.size = 2'd0;
                decoded.isLoad = 1'b1;
            end
            AguPkg::LHU: begin
                decoded.size = 2'd1;
                decoded.isLoad = 1'b1;
            end
            // Store lanes follow the low address bits
            AguPkg::SB: begin
                decoded.size = 2'd0;
                decoded.isStore = 1'b1;
                decoded.wmask = 4'b0001 << addr[1:0];
            end
            AguPkg::SH: begin
                decoded.size = 2'd1;
                decoded.isStore = 1'b1;
                decoded.wmask = addr[1] ? 4'b1100 : 4'b0011;
            end
            AguPkg::SW: begin
                decoded.size = 2'd2;
                decoded.isStore = 1'b1;
                decoded.wmask = 4'b1111;
            end
            default: begin
                decoded.size = 2'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/DataTlb.sv
`timescale 1ns/1ps
`default_nettype none

module DataTlb #(
    parameter int entries = 4
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire AguPkg::TlbLookup   lookup,
    output AguPkg::TlbEntry         result,
    input  wire AguPkg::PageWalkRes pwRes
);

    localparam int idxW = $clog2(entries);

    logic [entries-1:0] valid;
    logic [19:0]        vpn [entries];
    AguPkg::TlbEntry    data [entries];
    logic [idxW-1:0]    ptr;
    logic               dupVpn;

    always_comb begin
        result = '0;
        for (int i = 0; i < entries; i++) begin
            if (lookup.valid && valid[i] && vpn[i] == lookup.vpn)
                result = data[i];
        end
    end

    // Refill overwrites the round-robin victim
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            ptr <= '0;
        end else if (pwRes.valid) begin
            valid[ptr] <= 1'b1;
            vpn[ptr] <= pwRes.vpn;
            data[ptr] <= '{hit: 1'b1, ppn: pwRes.ppn, rwx: pwRes.rwx,
                           user: pwRes.user, pageFault: pwRes.pageFault};
            ptr <= (ptr == idxW'(entries - 1)) ? '0 : ptr + 1'b1;
        end
    end

    always_comb begin
        dupVpn = 1'b0;
        for (int i = 0; i < entries; i++) begin
            for (int j = i + 1; j < entries; j++) begin
                if (valid[i] && valid[j] && vpn[i] == vpn[j])
                    dupVpn = 1'b1;
            end
        end
    end

    // Only one walk per page may be in flight
    assert property (@(posedge clk) disable iff (rst) !dupVpn);

endmodule

`default_nettype wire

// File: design/TlbMissQueue.sv
`timescale 1ns/1ps
`default_nettype none

module TlbMissQueue #(
    parameter int depth = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        enqueue,
    input  wire AguPkg::AguUop         uopIn,
    input  wire                        dequeue,
    output AguPkg::AguUop              head,
    output logic [$clog2(depth):0]     free,
    input  wire AguPkg::BranchFlush    branch,
    input  wire AguPkg::PageWalkRes    pwRes
);

    localparam int idxW = $clog2(depth);

    AguPkg::AguUop    mem [depth];
    logic [depth-1:0] used;
    logic [depth-1:0] ready;
    logic [idxW-1:0]  headIdx;
    logic [idxW-1:0]  freeIdx;
    logic             headFound;

    always_comb begin
        headFound = 1'b0;
        headIdx = '0;
        freeIdx = '0;
        free = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!used[i]) begin
                freeIdx = idxW'(i);
                free = free + 1'b1;
            end
        end
        // Oldest ready slot by sequence number
        for (int i = 0; i < depth; i++) begin
            if (used[i] && ready[i] &&
                (!headFound || AguPkg::isYounger(mem[headIdx].sqN, mem[i].sqN))) begin
                headFound = 1'b1;
                headIdx = idxW'(i);
            end
        end
        head = mem[headIdx];
        head.valid = headFound;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            used <= '0;
        end else begin
            for (int i = 0; i < depth; i++) begin
                // Other pages replay too, miss again and start their own walk
                if (pwRes.valid)
                    ready[i] <= 1'b1;
                if (branch.taken && AguPkg::isYounger(mem[i].sqN, branch.sqN))
                    used[i] <= 1'b0;
            end
            // Replayed head that missed again stays parked in its slot
            if (dequeue && enqueue) begin
                ready[headIdx] <= pwRes.valid;
            end else begin
                if (dequeue)
                    used[headIdx] <= 1'b0;
                if (enqueue) begin
                    used[freeIdx] <= 1'b1;
                    ready[freeIdx] <= pwRes.valid;
                    mem[freeIdx] <= uopIn;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) enqueue && free == 0 |-> dequeue);
    assert property (@(posedge clk) disable iff (rst) dequeue |-> head.valid);

endmodule

`default_nettype wire

// File: design/AddrGenUnit.sv
`timescale 1ns/1ps
`default_nettype none

module AddrGenUnit #(
    parameter int         tmqDepth = 4,
    parameter logic [1:0] rqId = 2'd1
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire AguPkg::IssueUop         uopIn,
    input  wire AguPkg::AguUop           decoded,
    output logic [31:0]                  addr,
    output AguPkg::TlbLookup             tlbLookup,
    input  wire AguPkg::TlbEntry         tlbResult,
    input  wire AguPkg::AguUop           tmqHead,
    input  wire [$clog2(tmqDepth):0]     tmqFree,
    output logic                         tmqEnqueue,
    output logic                         tmqDequeue,
    input  wire AguPkg::BranchFlush      branch,
    input  wire AguPkg::VmemState        vmem,
    output AguPkg::PageWalkReq           pwReq,
    input  wire AguPkg::PageWalkRes      pwRes,
    output AguPkg::AguUop                aguOut,
    output AguPkg::TvalReport            tval,
    output logic                         stall
);

    AguPkg::AguUop      issUop;
    AguPkg::AguException except;
    logic               fromQueue;
    logic               flushed;
    logic               misaligned;
    logic               permFault;
    logic               tlbMiss;
    logic [31:0]        phyAddr;
    logic               walkActive;
    logic               walkAccepted;

    assign addr = uopIn.srcA + uopIn.srcB;
    assign stall = (tmqFree == 0);

    // Incoming op wins, parked ops fill idle cycles
    always_comb begin
        issUop = tmqHead;
        fromQueue = tmqHead.valid;
        if (decoded.valid && !stall) begin
            issUop = decoded;
            fromQueue = 1'b0;
        end
    end

    assign flushed = branch.taken && AguPkg::isYounger(issUop.sqN, branch.sqN);
    assign tlbLookup = '{valid: vmem.sv32en && issUop.valid, vpn: issUop.addr[31:12]};
    assign phyAddr = vmem.sv32en ? {tlbResult.ppn, issUop.addr[11:0]} : issUop.addr;

    always_comb begin
        misaligned = (issUop.size == 2'd1 && issUop.addr[0]) ||
                     (issUop.size == 2'd2 && issUop.addr[1:0] != 2'b00);
        permFault = (issUop.isLoad && !tlbResult.rwx[2]) ||
                    (issUop.isStore && !tlbResult.rwx[1]) ||
                    (vmem.priv == AguPkg::PRIV_USER && !tlbResult.user) ||
                    (vmem.priv == AguPkg::PRIV_SUPERVISOR && tlbResult.user && !vmem.sum);
        except = AguPkg::NONE;
        if (misaligned)
            except = AguPkg::MISALIGN;
        else if (vmem.sv32en && tlbResult.hit && (tlbResult.pageFault || permFault))
            except = AguPkg::PAGE_FAULT;
        else if (!(vmem.sv32en && !tlbResult.hit) && !AguPkg::isLegalAddr(phyAddr))
            except = AguPkg::ACCESS_FAULT;
    end

    // Faulting ops skip the walk and report right away
    assign tlbMiss = issUop.valid && vmem.sv32en && !tlbResult.hit && except == AguPkg::NONE;
    assign tmqEnqueue = tlbMiss && !flushed;
    assign tmqDequeue = fromQueue;

    always_ff @(posedge clk) begin
        if (rst) begin
            aguOut.valid <= 1'b0;
            tval.valid <= 1'b0;
            pwReq.valid <= 1'b0;
            walkActive <= 1'b0;
            walkAccepted <= 1'b0;
        end else begin
            aguOut.valid <= 1'b0;
            tval.valid <= 1'b0;
            if (issUop.valid && !flushed && !tlbMiss) begin
                aguOut <= issUop;
                aguOut.addr <= phyAddr;
                aguOut.exception <= except;
                tval <= '{valid: except != AguPkg::NONE, sqN: issUop.sqN, tval: issUop.addr};
            end

            // Request held until the walker grants our id
            if (walkActive) begin
                if (!walkAccepted) begin
                    if (pwRes.busy && pwRes.rqId == rqId) begin
                        walkAccepted <= 1'b1;
                        pwReq.valid <= 1'b0;
                    end
                end else if (pwRes.valid) begin
                    walkActive <= 1'b0;
                    walkAccepted <= 1'b0;
                end
            end else if (tmqEnqueue) begin
                walkActive <= 1'b1;
                walkAccepted <= 1'b0;
                pwReq <= '{valid: 1'b1, addr: issUop.addr};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/AguTop.sv
`timescale 1ns/1ps
`default_nettype none

module AguTop #(
    parameter int         tmqDepth = 4,
    parameter int         tlbEntries = 4,
    parameter logic [1:0] rqId = 2'd1
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire AguPkg::IssueUop    uopIn,
    input  wire AguPkg::BranchFlush branch,
    input  wire AguPkg::VmemState   vmem,
    input  wire AguPkg::PageWalkRes pwRes,
    output AguPkg::AguUop           aguOut,
    output AguPkg::TvalReport       tval,
    output AguPkg::PageWalkReq      pwReq,
    output logic                    stall
);

    AguPkg::AguUop          decoded;
    AguPkg::AguUop          tmqHead;
    AguPkg::TlbLookup       tlbLookup;
    AguPkg::TlbEntry        tlbResult;
    logic [31:0]            vaddr;
    logic [$clog2(tmqDepth):0] tmqFree;
    logic                   tmqEnqueue;
    logic                   tmqDequeue;

    MemOpDecode decodeInst (
        .uopIn(uopIn),
        .addr(vaddr),
        .decoded(decoded)
    );

    DataTlb #(.entries(tlbEntries)) tlbInst (
        .clk(clk),
        .rst(rst),
        .lookup(tlbLookup),
        .result(tlbResult),
        .pwRes(pwRes)
    );

    TlbMissQueue #(.depth(tmqDepth)) tmqInst (
        .clk(clk),
        .rst(rst),
        .enqueue(tmqEnqueue),
        .uopIn(decoded),
        .dequeue(tmqDequeue),
        .head(tmqHead),
        .free(tmqFree),
        .branch(branch),
        .pwRes(pwRes)
    );

    AddrGenUnit #(.tmqDepth(tmqDepth), .rqId(rqId)) agUnitInst (
        .clk(clk),
        .rst(rst),
        .uopIn(uopIn),
        .decoded(decoded),
        .addr(vaddr),
        .tlbLookup(tlbLookup),
        .tlbResult(tlbResult),
        .tmqHead(tmqHead),
        .tmqFree(tmqFree),
        .tmqEnqueue(tmqEnqueue),
        .tmqDequeue(tmqDequeue),
        .branch(branch),
        .vmem(vmem),
        .pwReq(pwReq),
        .pwRes(pwRes),
        .aguOut(aguOut),
        .tval(tval),
        .stall(stall)
    );

endmodule

`default_nettype wire

// File: testbench/AguTbTasks.svh
`ifndef AGU_TB_TASKS_SVH
`define AGU_TB_TASKS_SVH

    function automatic AguPkg::AguUop expectUop(AguPkg::MemOpcode op, logic [31:0] addr,
                                               logic [5:0] tag, AguPkg::SeqNum sqN,
                                               AguPkg::AguException exc);
        AguPkg::AguUop exp;
        exp = '0;
        exp.valid = 1'b1;
        exp.addr = addr;
        exp.tagDst = tag;
        exp.sqN = sqN;
        exp.exception = exc;
        exp.isStore = (op == AguPkg::SB || op == AguPkg::SH || op == AguPkg::SW);
        exp.isLoad = !exp.isStore;
        // Word loads fill the register, no extension
        exp.signExtend = (op == AguPkg::LB || op == AguPkg::LH);
        case (op)
            AguPkg::LB, AguPkg::LBU, AguPkg::SB: exp.size = 2'd0;
            AguPkg::LH, AguPkg::LHU, AguPkg::SH: exp.size = 2'd1;
            default: exp.size = 2'd2;
        endcase
        // Byte lanes spelled out per low address bits
        if (op == AguPkg::SB) begin
            case (addr[1:0])
                2'd0: exp.wmask = 4'b0001;
                2'd1: exp.wmask = 4'b0010;
                2'd2: exp.wmask = 4'b0100;
                default: exp.wmask = 4'b1000;
            endcase
        end else if (op == AguPkg::SH) begin
            case (addr[1:0])
                2'd0, 2'd1: exp.wmask = 4'b0011;
                default: exp.wmask = 4'b1100;
            endcase
        end else if (op == AguPkg::SW) begin
            exp.wmask = 4'b1111;
        end
        return exp;
    endfunction

    task automatic checkAguOut(AguPkg::AguUop exp, string what);
        if (aguOut.valid !== exp.valid || (exp.valid && aguOut !== exp))
            failRun($sformatf("ERROR at %0t: %s aguOut %h, expected %h",
                              $time, what, aguOut, exp));
    endtask

    task automatic checkTval(AguPkg::TvalReport exp, string what);
        if (tval.valid !== exp.valid || (exp.valid && tval !== exp))
            failRun($sformatf("ERROR at %0t: %s tval %h, expected %h",
                              $time, what, tval, exp));
    endtask

    task automatic checkPwReq(AguPkg::PageWalkReq exp, string what);
        if (pwReq.valid !== exp.valid || (exp.valid && pwReq !== exp))
            failRun($sformatf("ERROR at %0t: %s pwReq %h, expected %h",
                              $time, what, pwReq, exp));
    endtask

    task automatic checkStall(logic exp, string what);
        if (stall !== exp)
            failRun($sformatf("ERROR at %0t: %s stall %b, expected %b",
                              $time, what, stall, exp));
    endtask

    // Called just after an edge; the uop is held while stall is high
    task automatic issueUop(AguPkg::MemOpcode op, logic [31:0] base, logic [31:0] offset,
                            output AguPkg::SeqNum sqN, output logic [5:0] tag);
        logic taken;
        sqN = nextSqN;
        tag = 6'($random(seed));
        nextSqN = nextSqN + 1'b1;
        uopIn.valid = 1'b1;
        uopIn.opcode = op;
        uopIn.srcA = base;
        uopIn.srcB = offset;
        uopIn.tagDst = tag;
        uopIn.sqN = sqN;
        taken = 1'b0;
        while (!taken) begin
            taken = !stall;
            @(posedge clk);
            #2;
        end
        uopIn.valid = 1'b0;
    endtask

    task automatic runOp(AguPkg::MemOpcode op, logic [31:0] base, logic [31:0] offset,
                         logic [31:0] expAddr, AguPkg::AguException exc, logic miss);
        AguPkg::SeqNum     sqN;
        logic [5:0]        tag;
        logic [31:0]       vaddr;
        AguPkg::TvalReport expTval;
        vaddr = base + offset;
        issueUop(op, base, offset, sqN, tag);
        if (miss) begin
            checkAguOut('0, "TLB miss");
            checkPwReq('{valid: 1'b1, addr: vaddr}, "TLB miss");
            while (aguOut.valid !== 1'b1) begin
                @(posedge clk);
                #2;
            end
        end
        expTval = '{valid: exc != AguPkg::NONE, sqN: sqN, tval: vaddr};
        checkAguOut(expectUop(op, expAddr, tag, sqN, exc), op.name());
        checkTval(expTval, op.name());
    endtask

    task automatic testTranslationOff();
        AguPkg::MemOpcode op;
        logic [31:0]      base;
        logic [31:0]      offset;
        vmem = '0;
        for (int i = 0; i < 32; i++) begin
            op = AguPkg::MemOpcode'(i % 8);
            base = $random(seed) & 32'h07ff_fff0;
            offset = $random(seed) & 32'h0000_0fff;
            if (op == AguPkg::LH || op == AguPkg::LHU || op == AguPkg::SH)
                offset[0] = 1'b0;
            if (op == AguPkg::LW || op == AguPkg::SW)
                offset[1:0] = 2'b00;
            runOp(op, base, offset, base + offset, AguPkg::NONE, 1'b0);
        end
    endtask

    task automatic testFaultsPhysical();
        vmem = '0;
        runOp(AguPkg::LH, 32'h0000_1000, 32'h3, 32'h0000_1003, AguPkg::MISALIGN, 1'b0);
        runOp(AguPkg::SW, 32'h0000_2000, 32'h6, 32'h0000_2006, AguPkg::MISALIGN, 1'b0);
        runOp(AguPkg::LW, 32'h0000_3000, 32'h1, 32'h0000_3001, AguPkg::MISALIGN, 1'b0);
        runOp(AguPkg::LW, 32'h0fff_fff0, 32'h10, 32'h1000_0000, AguPkg::ACCESS_FAULT, 1'b0);
        runOp(AguPkg::SB, 32'h2000_0f00, 32'hff, 32'h2000_0fff, AguPkg::NONE, 1'b0);
        runOp(AguPkg::SH, 32'h2000_0ffe, 32'h2, 32'h2000_1000, AguPkg::ACCESS_FAULT, 1'b0);
        runOp(AguPkg::LBU, 32'h8000_0000, 32'h0, 32'h8000_0000, AguPkg::ACCESS_FAULT, 1'b0);
        // Misalignment wins over the range check
        runOp(AguPkg::LHU, 32'h3000_0000, 32'h1, 32'h3000_0001, AguPkg::MISALIGN, 1'b0);
    endtask

    task automatic testTranslationMiss();
        vmem = '{sv32en: 1'b1, priv: AguPkg::PRIV_SUPERVISOR, sum: 1'b1};
        runOp(AguPkg::LW, {20'h51230, 12'h100}, 32'h4, {tablePpn(20'h51230), 12'h104},
              AguPkg::NONE, 1'b1);
        runOp(AguPkg::SW, {20'h51230, 12'h200}, 32'h8, {tablePpn(20'h51230), 12'h208},
              AguPkg::NONE, 1'b0);
        runOp(AguPkg::SB, {20'h51230, 12'h7f0}, 32'h3, {tablePpn(20'h51230), 12'h7f3},
              AguPkg::NONE, 1'b0);
    endtask

    task automatic testPermissions();
        vmem = '{sv32en: 1'b1, priv: AguPkg::PRIV_SUPERVISOR, sum: 1'b0};
        runOp(AguPkg::SW, {20'h51232, 12'h040}, 32'h0, {tablePpn(20'h51232), 12'h040},
              AguPkg::PAGE_FAULT, 1'b1);
        vmem.priv = AguPkg::PRIV_USER;
        runOp(AguPkg::LW, {20'h51230, 12'h010}, 32'h0, {tablePpn(20'h51230), 12'h010},
              AguPkg::PAGE_FAULT, 1'b0);
        runOp(AguPkg::SW, {20'h51231, 12'h020}, 32'h0, {tablePpn(20'h51231), 12'h020},
              AguPkg::NONE, 1'b1);
        runOp(AguPkg::SW, {20'h51233, 12'h030}, 32'h0, {tablePpn(20'h51233), 12'h030},
              AguPkg::PAGE_FAULT, 1'b1);
        // User page from supervisor, first without sum
        vmem.priv = AguPkg::PRIV_SUPERVISOR;
        runOp(AguPkg::SW, {20'h51231, 12'h024}, 32'h0, {tablePpn(20'h51231), 12'h024},
              AguPkg::PAGE_FAULT, 1'b0);
        vmem.sum = 1'b1;
        runOp(AguPkg::SW, {20'h51231, 12'h028}, 32'h0, {tablePpn(20'h51231), 12'h028},
              AguPkg::NONE, 1'b0);
        runOp(AguPkg::LW, {20'h512ff, 12'h0f0}, 32'h0, {tablePpn(20'h512ff), 12'h0f0},
              AguPkg::PAGE_FAULT, 1'b1);
    endtask

    task automatic testQueueFlush();
        AguPkg::SeqNum sqN [4];
        logic [5:0]    tag [4];
        logic [19:0]   vpn [4];
        AguPkg::AguUop exp [2];
        int            seen;
        vmem = '{sv32en: 1'b1, priv: AguPkg::PRIV_SUPERVISOR, sum: 1'b1};
        vpn = '{20'h53010, 20'h53020, 20'h53030, 20'h53040};
        for (int i = 0; i < 4; i++)
            issueUop(AguPkg::LW, {vpn[i], 12'h000}, 32'h40 + 4 * i, sqN[i], tag[i]);
        checkStall(1'b1, "four parked misses");
        // Flush everything younger than the second op
        branch = '{taken: 1'b1, sqN: sqN[1]};
        @(posedge clk);
        #2;
        branch = '0;
        checkStall(1'b0, "after flush");
        exp[0] = expectUop(AguPkg::LW, {tablePpn(vpn[0]), 12'h040}, tag[0], sqN[0], AguPkg::NONE);
        exp[1] = expectUop(AguPkg::LW, {tablePpn(vpn[1]), 12'h044}, tag[1], sqN[1], AguPkg::NONE);
        seen = 0;
        repeat (40) begin
            if (aguOut.valid === 1'b1) begin
                if (seen >= 2)
                    failRun($sformatf("ERROR at %0t: flushed op sqN %0d reached aguOut",
                                      $time, aguOut.sqN));
                else begin
                    checkAguOut(exp[seen], "replay after flush");
                    seen++;
                end
            end
            @(posedge clk);
            #2;
        end
        if (seen != 2)
            failRun($sformatf("ERROR at %0t: only %0d of 2 older ops appeared", $time, seen));
    endtask

`endif

// File: testbench/AguTopTb.sv
`timescale 1ns/1ps
`default_nettype none

module AguTopTb;

    // The whole sequence needs about 200 cycles
    localparam int cycleLimit = 2000;

    logic               clk;
    logic               rst;
    AguPkg::IssueUop    uopIn;
    AguPkg::BranchFlush branch;
    AguPkg::VmemState   vmem;
    AguPkg::PageWalkRes pwRes;
    AguPkg::AguUop      aguOut;
    AguPkg::TvalReport  tval;
    AguPkg::PageWalkReq pwReq;
    logic               stall;

    integer        seed;
    int            cycles;
    AguPkg::SeqNum nextSqN;
    logic          walkBusy;
    int            walkCount;
    logic [19:0]   walkVpn;

    AguTop #(.tmqDepth(4), .tlbEntries(4), .rqId(2'd1)) AguTop_inst (
        .clk(clk),
        .rst(rst),
        .uopIn(uopIn),
        .branch(branch),
        .vmem(vmem),
        .pwRes(pwRes),
        .aguOut(aguOut),
        .tval(tval),
        .pwReq(pwReq),
        .stall(stall)
    );

    always #20 clk = ~clk;

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit)
            failRun($sformatf("Timeout: tests did not finish within %0d cycles", cycleLimit));
    end

    // Page table: ppn is vpn xor a constant, permissions from the low vpn bits
    function automatic logic [19:0] tablePpn(logic [19:0] vpn);
        return vpn ^ 20'h5a5a5;
    endfunction

    function automatic AguPkg::PageWalkRes walkResult(logic [19:0] vpn);
        AguPkg::PageWalkRes res;
        res = '0;
        res.valid = 1'b1;
        res.rqId = 2'd1;
        res.vpn = vpn;
        res.ppn = tablePpn(vpn);
        res.rwx = {1'b1, ~vpn[1], 1'b0};
        res.user = vpn[0];
        res.pageFault = (vpn[7:0] == 8'hff);
        return res;
    endfunction

    // Walker grants one cycle after a request, result three cycles later
    always @(posedge clk) begin
        logic        reqSeen;
        logic [19:0] reqVpn;
        reqSeen = pwReq.valid && !walkBusy && !pwRes.valid;
        reqVpn = pwReq.addr[31:12];
        #2;
        if (pwRes.valid) begin
            pwRes = '0;
        end else if (walkBusy) begin
            walkCount++;
            if (walkCount == 3) begin
                walkBusy = 1'b0;
                pwRes = walkResult(walkVpn);
            end
        end else if (reqSeen && !rst) begin
            walkBusy = 1'b1;
            walkCount = 0;
            walkVpn = reqVpn;
            pwRes = '0;
            pwRes.busy = 1'b1;
            pwRes.rqId = 2'd1;
        end
    end

    `include "AguTbTasks.svh"

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        uopIn = '0;
        branch = '0;
        vmem = '0;
        pwRes = '0;
        seed = 32'h96dd_e7ad;
        cycles = 0;
        nextSqN = '0;
        walkBusy = 1'b0;
        walkCount = 0;
        walkVpn = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        testTranslationOff();
        testFaultsPhysical();
        testTranslationMiss();
        testPermissions();
        testQueueFlush();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+testbench
design/AguPkg.sv
design/MemOpDecode.sv
design/DataTlb.sv
design/TlbMissQueue.sv
design/AddrGenUnit.sv
design/AguTop.sv
testbench/AguTopTb.sv
